// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0000;  // sll r0,r0,0

    // instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    // instr[5:0] of R-type
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpE;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // value read in decode
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSelE;

endpackage

`default_nettype wire

// File: fetch/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     stall_i,
    input  logic                     flushD_i,
    input  logic                     memStall_i,
    input  logic                     jumpD_i,
    input  logic [mipsPkg::XLEN-1:0] jumpTargetD_i,
    input  logic                     branchTakenE_i,
    input  logic [mipsPkg::XLEN-1:0] branchTargetE_i,
    input  logic [mipsPkg::XLEN-1:0] instr_i,
    output logic [mipsPkg::XLEN-1:0] instAddr_o,
    output logic                     instEn_o,
    output logic [mipsPkg::XLEN-1:0] pcD_o,
    output logic [mipsPkg::XLEN-1:0] instrD_o
);
    import mipsPkg::*;

    logic [XLEN-1:0] pcF;
    logic [XLEN-1:0] pcNext;

    // branch in execute is older than a jump in decode
    always_comb begin
        if (branchTakenE_i) begin
            pcNext = branchTargetE_i;
        end else if (stall_i) begin
            pcNext = pcF;
        end else if (jumpD_i) begin
            pcNext = jumpTargetD_i;
        end else begin
            pcNext = pcF + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pcF <= RESET_PC;
        end else if (!memStall_i) begin
            pcF <= pcNext;
        end
    end

    assign instAddr_o = pcF;
    assign instEn_o   = !(stall_i || memStall_i);

    // IF/ID
    always_ff @(posedge clk) begin
        if (rst_i) begin
            instrD_o <= NOP_INSTR;
        end else if (!memStall_i) begin
            if (flushD_i) begin
                instrD_o <= NOP_INSTR;  // flush beats the load-use hold
            end else if (!stall_i) begin
                instrD_o <= instr_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!memStall_i && !stall_i) begin
            pcD_o <= pcF;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst_i)
        pcF[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] raddrA_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] raddrB_i,
    input  logic                           we_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [mipsPkg::XLEN-1:0]       wdata_i,
    output logic [mipsPkg::XLEN-1:0]       rdataA_o,
    output logic [mipsPkg::XLEN-1:0]       rdataB_o
);
    import mipsPkg::*;

    logic [XLEN-1:0] regs [0:31];

    function automatic logic [XLEN-1:0] readReg(input logic [REG_ADDR_W-1:0] addr);
        if (we_i && waddr_i == addr && addr != '0) begin
            return wdata_i;  // writeback visible in the same cycle
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdataA_o = readReg(raddrA_i);
        rdataB_o = readReg(raddrB_i);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            regs[0] <= '0;  // r0 cleared here and never written
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    zeroWriteIgnored: assert property (@(posedge clk) disable iff (rst_i)
        regs[0] == '0);

endmodule

`default_nettype wire

// File: source/decodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [mipsPkg::XLEN-1:0]       pcD_i,
    input  logic [mipsPkg::XLEN-1:0]       instrD_i,
    input  logic                           regWeW_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] regWaddrW_i,
    input  logic [mipsPkg::XLEN-1:0]       resultW_i,
    output logic [mipsPkg::REG_ADDR_W-1:0] rsD_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] rtD_o,
    output logic [mipsPkg::XLEN-1:0]       rdataAD_o,
    output logic [mipsPkg::XLEN-1:0]       rdataBD_o,
    output logic [mipsPkg::XLEN-1:0]       immD_o,
    output mipsPkg::aluOpE                 aluOpD_o,
    output logic                           aluSrcImmD_o,
    output logic                           regWeD_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] regWaddrD_o,
    output logic                           memReadD_o,
    output logic                           memWriteD_o,
    output logic                           branchD_o,
    output logic                           jumpD_o,
    output logic [mipsPkg::XLEN-1:0]       jumpTargetD_o
);
    import mipsPkg::*;

    opcodeE          opcode;
    functE           funct;
    logic [XLEN-1:0] pcPlus4;

    assign opcode = opcodeE'(instrD_i[31:26]);
    assign funct  = functE'(instrD_i[5:0]);
    assign rsD_o  = instrD_i[25:21];
    assign rtD_o  = instrD_i[20:16];
    assign immD_o = {{16{instrD_i[15]}}, instrD_i[15:0]};

    assign pcPlus4       = pcD_i + 32'd4;
    assign jumpTargetD_o = {pcPlus4[31:28], instrD_i[25:0], 2'b00};

    always_comb begin
        aluOpD_o     = ALU_ADD;
        aluSrcImmD_o = 1'b0;
        regWeD_o     = 1'b0;
        regWaddrD_o  = instrD_i[15:11];  // rd
        memReadD_o   = 1'b0;
        memWriteD_o  = 1'b0;
        branchD_o    = 1'b0;
        jumpD_o      = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                regWeD_o = 1'b1;
                case (funct)
                    FN_ADDU: aluOpD_o = ALU_ADD;
                    FN_SUBU: aluOpD_o = ALU_SUB;
                    FN_AND:  aluOpD_o = ALU_AND;
                    FN_OR:   aluOpD_o = ALU_OR;
                    FN_SLT:  aluOpD_o = ALU_SLT;
                    default: regWeD_o = 1'b0;  // sll r0 etc. act as nop
                endcase
            end
            OP_ADDIU: begin
                aluSrcImmD_o = 1'b1;
                regWeD_o     = 1'b1;
                regWaddrD_o  = rtD_o;
            end
            OP_LW: begin
                aluSrcImmD_o = 1'b1;
                regWeD_o     = 1'b1;
                regWaddrD_o  = rtD_o;
                memReadD_o   = 1'b1;
            end
            OP_SW: begin
                aluSrcImmD_o = 1'b1;
                memWriteD_o  = 1'b1;
            end
            OP_BEQ: branchD_o = 1'b1;
            OP_J:   jumpD_o   = 1'b1;
            default: ;
        endcase
    end

    regFile u_regFile (
        .clk      (clk),
        .rst_i    (rst_i),
        .raddrA_i (rsD_o),
        .raddrB_i (rtD_o),
        .we_i     (regWeW_i),
        .waddr_i  (regWaddrW_i),
        .wdata_i  (resultW_i),
        .rdataA_o (rdataAD_o),
        .rdataB_o (rdataBD_o)
    );

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsE_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtE_i,
    input  logic                           memReadE_i,
    input  logic                           regWeM_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] regWaddrM_i,
    input  logic                           regWeW_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] regWaddrW_i,
    input  logic                           branchTakenE_i,
    input  logic                           jumpD_i,
    output logic                           stallF_o,
    output logic                           stallD_o,
    output logic                           flushD_o,
    output logic                           flushE_o,
    output mipsPkg::fwdSelE                fwdA_o,
    output mipsPkg::fwdSelE                fwdB_o
);
    import mipsPkg::*;

    logic loadUse;

    // memory stage is younger, so it wins over writeback
    function automatic fwdSelE fwdSel(input logic [REG_ADDR_W-1:0] src);
        if (src == '0) begin
            return FWD_REG;
        end
        if (regWeM_i && regWaddrM_i == src) begin
            return FWD_MEM;
        end
        if (regWeW_i && regWaddrW_i == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwdA_o = fwdSel(rsE_i);
        fwdB_o = fwdSel(rtE_i);
    end

    assign loadUse = memReadE_i && rtE_i != '0 && (rtE_i == rsD_i || rtE_i == rtD_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushE_o = loadUse || branchTakenE_i;
    assign flushD_o = branchTakenE_i || (jumpD_i && !loadUse);  // held jump redirects later

endmodule

`default_nettype wire

// File: execute/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    input  logic [mipsPkg::XLEN-1:0]       pcD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtD_i,
    input  logic [mipsPkg::XLEN-1:0]       rdataAD_i,
    input  logic [mipsPkg::XLEN-1:0]       rdataBD_i,
    input  logic [mipsPkg::XLEN-1:0]       immD_i,
    input  mipsPkg::aluOpE                 aluOpD_i,
    input  logic                           aluSrcImmD_i,
    input  logic                           regWeD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] regWaddrD_i,
    input  logic                           memReadD_i,
    input  logic                           memWriteD_i,
    input  logic                           branchD_i,
    input  mipsPkg::fwdSelE                fwdA_i,
    input  mipsPkg::fwdSelE                fwdB_i,
    input  logic [mipsPkg::XLEN-1:0]       resultM_i,
    input  logic [mipsPkg::XLEN-1:0]       resultW_i,
    output logic [mipsPkg::REG_ADDR_W-1:0] rsE_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] rtE_o,
    output logic                           memReadE_o,
    output logic [mipsPkg::XLEN-1:0]       aluOutE_o,
    output logic [mipsPkg::XLEN-1:0]       storeDataE_o,
    output logic                           regWeE_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] regWaddrE_o,
    output logic                           memWriteE_o,
    output logic                           branchTakenE_o,
    output logic [mipsPkg::XLEN-1:0]       branchTargetE_o
);
    import mipsPkg::*;

    logic [XLEN-1:0] pcE;
    logic [XLEN-1:0] rdataAE;
    logic [XLEN-1:0] rdataBE;
    logic [XLEN-1:0] immE;
    aluOpE           aluCtrlE;
    logic            aluSrcImmE;
    logic            branchE;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluB;

    function automatic logic [XLEN-1:0] fwdMux(input fwdSelE sel, input logic [XLEN-1:0] regVal,
                                               input logic [XLEN-1:0] memVal,
                                               input logic [XLEN-1:0] wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // ID/EX control
    always_ff @(posedge clk) begin
        if (rst_i) begin
            regWeE_o    <= 1'b0;
            memReadE_o  <= 1'b0;
            memWriteE_o <= 1'b0;
            branchE     <= 1'b0;
        end else if (!stall_i) begin
            regWeE_o    <= regWeD_i && !flush_i;
            memReadE_o  <= memReadD_i && !flush_i;
            memWriteE_o <= memWriteD_i && !flush_i;
            branchE     <= branchD_i && !flush_i;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcE         <= pcD_i;
            rsE_o       <= rsD_i;
            rtE_o       <= rtD_i;
            rdataAE     <= rdataAD_i;
            rdataBE     <= rdataBD_i;
            immE        <= immD_i;
            aluCtrlE    <= aluOpD_i;
            aluSrcImmE  <= aluSrcImmD_i;
            regWaddrE_o <= regWaddrD_i;
        end
    end

    assign srcA = fwdMux(fwdA_i, rdataAE, resultM_i, resultW_i);
    assign srcB = fwdMux(fwdB_i, rdataBE, resultM_i, resultW_i);
    assign aluB = aluSrcImmE ? immE : srcB;

    always_comb begin
        case (aluCtrlE)
            ALU_SUB: aluOutE_o = srcA - aluB;
            ALU_AND: aluOutE_o = srcA & aluB;
            ALU_OR:  aluOutE_o = srcA | aluB;
            ALU_SLT: aluOutE_o = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(aluB)};
            default: aluOutE_o = srcA + aluB;
        endcase
    end

    assign storeDataE_o    = srcB;
    assign branchTakenE_o  = branchE && (srcA == srcB);
    assign branchTargetE_o = pcE + 32'd4 + {immE[XLEN-3:0], 2'b00};

endmodule

`default_nettype wire

// File: memwb/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           memStall_i,
    input  logic [mipsPkg::XLEN-1:0]       aluOutE_i,
    input  logic [mipsPkg::XLEN-1:0]       storeDataE_i,
    input  logic                           regWeE_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] regWaddrE_i,
    input  logic                           memReadE_i,
    input  logic                           memWriteE_i,
    input  logic [mipsPkg::XLEN-1:0]       dataRdata_i,
    output logic                           dataEn_o,
    output logic                           dataWe_o,
    output logic [mipsPkg::XLEN-1:0]       dataAddr_o,
    output logic [mipsPkg::XLEN-1:0]       dataWdata_o,
    output logic [mipsPkg::XLEN-1:0]       resultM_o,
    output logic                           regWeM_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] regWaddrM_o,
    output logic                           regWeW_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] regWaddrW_o,
    output logic [mipsPkg::XLEN-1:0]       resultW_o
);
    import mipsPkg::*;

    logic            memReadM;
    logic            memWriteM;
    logic [XLEN-1:0] aluOutM;
    logic [XLEN-1:0] storeDataM;

    // EX/MEM and MEM/WB control frozen while memory stalls
    always_ff @(posedge clk) begin
        if (rst_i) begin
            regWeM_o  <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            regWeW_o  <= 1'b0;
        end else if (!memStall_i) begin
            regWeM_o  <= regWeE_i;
            memReadM  <= memReadE_i;
            memWriteM <= memWriteE_i;
            regWeW_o  <= regWeM_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!memStall_i) begin
            aluOutM     <= aluOutE_i;
            storeDataM  <= storeDataE_i;
            regWaddrM_o <= regWaddrE_i;
            regWaddrW_o <= regWaddrM_o;
            resultW_o   <= resultM_o;
        end
    end

    assign dataEn_o    = memReadM || memWriteM;
    assign dataWe_o    = memWriteM;
    assign dataAddr_o  = aluOutM;
    assign dataWdata_o = storeDataM;

    assign resultM_o = memReadM ? dataRdata_i : aluOutM;  // load data is same-cycle

    dataAligned: assert property (@(posedge clk) disable iff (rst_i)
        dataEn_o |-> dataAddr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic [mipsPkg::XLEN-1:0] instr_i,
    output logic [mipsPkg::XLEN-1:0] instAddr_o,
    output logic                     instEn_o,
    input  logic [mipsPkg::XLEN-1:0] dataRdata_i,
    input  logic                     memStall_i,
    output logic                     dataEn_o,
    output logic                     dataWe_o,
    output logic [mipsPkg::XLEN-1:0] dataAddr_o,
    output logic [mipsPkg::XLEN-1:0] dataWdata_o
);
    import mipsPkg::*;

    logic [XLEN-1:0]       pcD;
    logic [XLEN-1:0]       instrD;
    logic [REG_ADDR_W-1:0] rsD;
    logic [REG_ADDR_W-1:0] rtD;
    logic [XLEN-1:0]       rdataAD;
    logic [XLEN-1:0]       rdataBD;
    logic [XLEN-1:0]       immD;
    aluOpE                 aluOpD;
    logic                  aluSrcImmD;
    logic                  regWeD;
    logic [REG_ADDR_W-1:0] regWaddrD;
    logic                  memReadD;
    logic                  memWriteD;
    logic                  branchD;
    logic                  jumpD;
    logic [XLEN-1:0]       jumpTargetD;
    logic [REG_ADDR_W-1:0] rsE;
    logic [REG_ADDR_W-1:0] rtE;
    logic                  memReadE;
    logic [XLEN-1:0]       aluOutE;
    logic [XLEN-1:0]       storeDataE;
    logic                  regWeE;
    logic [REG_ADDR_W-1:0] regWaddrE;
    logic                  memWriteE;
    logic                  branchTakenE;
    logic [XLEN-1:0]       branchTargetE;
    logic [XLEN-1:0]       resultM;
    logic                  regWeM;
    logic [REG_ADDR_W-1:0] regWaddrM;
    logic                  regWeW;
    logic [REG_ADDR_W-1:0] regWaddrW;
    logic [XLEN-1:0]       resultW;
    logic                  stallF;
    logic                  stallD;
    logic                  flushD;
    logic                  flushE;
    fwdSelE                fwdA;
    fwdSelE                fwdB;

    fetchStage u_fetch (
        .clk             (clk),
        .rst_i           (rst_i),
        .stall_i         (stallF || stallD),
        .flushD_i        (flushD),
        .memStall_i      (memStall_i),
        .jumpD_i         (jumpD),
        .jumpTargetD_i   (jumpTargetD),
        .branchTakenE_i  (branchTakenE),
        .branchTargetE_i (branchTargetE),
        .instr_i         (instr_i),
        .instAddr_o      (instAddr_o),
        .instEn_o        (instEn_o),
        .pcD_o           (pcD),
        .instrD_o        (instrD)
    );

    decodeUnit u_decode (
        .clk           (clk),
        .rst_i         (rst_i),
        .pcD_i         (pcD),
        .instrD_i      (instrD),
        .regWeW_i      (regWeW),
        .regWaddrW_i   (regWaddrW),
        .resultW_i     (resultW),
        .rsD_o         (rsD),
        .rtD_o         (rtD),
        .rdataAD_o     (rdataAD),
        .rdataBD_o     (rdataBD),
        .immD_o        (immD),
        .aluOpD_o      (aluOpD),
        .aluSrcImmD_o  (aluSrcImmD),
        .regWeD_o      (regWeD),
        .regWaddrD_o   (regWaddrD),
        .memReadD_o    (memReadD),
        .memWriteD_o   (memWriteD),
        .branchD_o     (branchD),
        .jumpD_o       (jumpD),
        .jumpTargetD_o (jumpTargetD)
    );

    executeStage u_execute (
        .clk             (clk),
        .rst_i           (rst_i),
        .stall_i         (memStall_i),
        .flush_i         (flushE),
        .pcD_i           (pcD),
        .rsD_i           (rsD),
        .rtD_i           (rtD),
        .rdataAD_i       (rdataAD),
        .rdataBD_i       (rdataBD),
        .immD_i          (immD),
        .aluOpD_i        (aluOpD),
        .aluSrcImmD_i    (aluSrcImmD),
        .regWeD_i        (regWeD),
        .regWaddrD_i     (regWaddrD),
        .memReadD_i      (memReadD),
        .memWriteD_i     (memWriteD),
        .branchD_i       (branchD),
        .fwdA_i          (fwdA),
        .fwdB_i          (fwdB),
        .resultM_i       (resultM),
        .resultW_i       (resultW),
        .rsE_o           (rsE),
        .rtE_o           (rtE),
        .memReadE_o      (memReadE),
        .aluOutE_o       (aluOutE),
        .storeDataE_o    (storeDataE),
        .regWeE_o        (regWeE),
        .regWaddrE_o     (regWaddrE),
        .memWriteE_o     (memWriteE),
        .branchTakenE_o  (branchTakenE),
        .branchTargetE_o (branchTargetE)
    );

    memStage u_mem (
        .clk          (clk),
        .rst_i        (rst_i),
        .memStall_i   (memStall_i),
        .aluOutE_i    (aluOutE),
        .storeDataE_i (storeDataE),
        .regWeE_i     (regWeE),
        .regWaddrE_i  (regWaddrE),
        .memReadE_i   (memReadE),
        .memWriteE_i  (memWriteE),
        .dataRdata_i  (dataRdata_i),
        .dataEn_o     (dataEn_o),
        .dataWe_o     (dataWe_o),
        .dataAddr_o   (dataAddr_o),
        .dataWdata_o  (dataWdata_o),
        .resultM_o    (resultM),
        .regWeM_o     (regWeM),
        .regWaddrM_o  (regWaddrM),
        .regWeW_o     (regWeW),
        .regWaddrW_o  (regWaddrW),
        .resultW_o    (resultW)
    );

    hazardUnit u_hazard (
        .rsD_i          (rsD),
        .rtD_i          (rtD),
        .rsE_i          (rsE),
        .rtE_i          (rtE),
        .memReadE_i     (memReadE),
        .regWeM_i       (regWeM),
        .regWaddrM_i    (regWaddrM),
        .regWeW_i       (regWeW),
        .regWaddrW_i    (regWaddrW),
        .branchTakenE_i (branchTakenE),
        .jumpD_i        (jumpD),
        .stallF_o       (stallF),
        .stallD_o       (stallD),
        .flushD_o       (flushD),
        .flushE_o       (flushE),
        .fwdA_o         (fwdA),
        .fwdB_o         (fwdB)
    );

endmodule

`default_nettype wire

// File: tb/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// body runs twice, r20 counts passes and r21 holds the pass limit
task automatic loadProgram;
    for (int i = 0; i < 64; i++) begin
        rom[i] = encJ(i);  // unused words trap into a jump to themselves
    end
    rom[0]  = encI(6'h09, 0, 20, 16'd0);     // addiu r20,r0,0
    rom[1]  = encI(6'h09, 0, 21, 16'd2);     // addiu r21,r0,2
    rom[2]  = encI(6'h09, 0, 1, 16'h0035);   // body start
    rom[3]  = encI(6'h09, 1, 2, 16'h001c);
    rom[4]  = encR(6'h21, 3, 1, 2);          // addu r3,r1,r2
    rom[5]  = encR(6'h23, 4, 3, 1);          // subu r4,r3,r1
    rom[6]  = encR(6'h24, 5, 4, 1);          // and  r5,r4,r1
    rom[7]  = encR(6'h25, 6, 5, 3);          // or   r6,r5,r3
    rom[8]  = encR(6'h2a, 7, 5, 6);          // slt  r7,r5,r6
    rom[9]  = encI(6'h2b, 0, 2, 16'd0);
    rom[10] = encI(6'h2b, 0, 3, 16'd4);
    rom[11] = encI(6'h2b, 0, 4, 16'd8);
    rom[12] = encI(6'h2b, 0, 5, 16'd12);
    rom[13] = encI(6'h2b, 0, 6, 16'd16);
    rom[14] = encI(6'h2b, 0, 7, 16'd20);
    rom[15] = encI(6'h23, 0, 8, 16'd4);      // lw r8,4(r0)
    rom[16] = encR(6'h21, 9, 8, 1);          // load-use
    rom[17] = encI(6'h2b, 0, 9, 16'd24);
    rom[18] = encI(6'h04, 1, 1, 16'd1);      // beq taken
    rom[19] = encI(6'h2b, 0, 1, 16'd60);     // never stored
    rom[20] = encI(6'h2b, 0, 1, 16'd28);
    rom[21] = encI(6'h04, 1, 2, 16'd1);      // beq not taken
    rom[22] = encI(6'h2b, 0, 1, 16'd32);
    rom[23] = encJ(25);
    rom[24] = encI(6'h2b, 0, 1, 16'd56);     // never stored
    rom[25] = encI(6'h2b, 0, 3, 16'd36);
    rom[26] = encI(6'h09, 20, 20, 16'd1);
    rom[27] = encI(6'h04, 20, 21, 16'd1);
    rom[28] = encJ(2);
    rom[29] = encJ(29);                      // halt
endtask

task automatic loadExpected;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    logic [31:0] r6;
    logic [31:0] r7;
    logic [31:0] vals [0:9];
    logic [31:0] addrs [0:9];
    r1 = 32'h35;
    r2 = r1 + 32'h1c;
    r3 = r1 + r2;
    r4 = r3 - r1;
    r5 = r4 & r1;
    r6 = r5 | r3;
    r7 = ($signed(r5) < $signed(r6)) ? 32'd1 : 32'd0;
    vals  = '{r2, r3, r4, r5, r6, r7, r3 + r1, r1, r1, r3};  // lw returns r3
    addrs = '{0, 4, 8, 12, 16, 20, 24, 28, 32, 36};
    for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < PASS_STORES; i++) begin
            expAddr[p*PASS_STORES+i] = addrs[i];
            expData[p*PASS_STORES+i] = vals[i];
        end
    end
endtask

`endif

// File: tb/tbMipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore;

    localparam int PASS_STORES = 10;
    localparam int STORES      = 20;
    localparam int WAIT_LIMIT  = 3000;

    logic        clk;
    logic        rst_i;
    logic        memStall_i;
    logic [31:0] instr_i;
    logic [31:0] dataRdata_i;
    logic [31:0] instAddr_o;
    logic        instEn_o;
    logic        dataEn_o;
    logic        dataWe_o;
    logic [31:0] dataAddr_o;
    logic [31:0] dataWdata_o;

    logic [31:0] rom [0:63];
    logic [31:0] ram [0:63];
    logic [31:0] expAddr [0:STORES-1];
    logic [31:0] expData [0:STORES-1];
    logic [31:0] expAddrNow;
    logic [31:0] expDataNow;
    logic        storeFire;
    logic        stallOn;
    int          storeIdx;
    int          fails [0:5];
    string       testNames [0:5];
    int          seed;
    int          rnd;
    bit          timedOut;

    function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input int index);
        logic [25:0] idx;
        idx = index[25:0];
        return {6'h02, idx};
    endfunction

    `include "tbProgram.svh"

    mipsCore u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .instr_i     (instr_i),
        .instAddr_o  (instAddr_o),
        .instEn_o    (instEn_o),
        .dataRdata_i (dataRdata_i),
        .memStall_i  (memStall_i),
        .dataEn_o    (dataEn_o),
        .dataWe_o    (dataWe_o),
        .dataAddr_o  (dataAddr_o),
        .dataWdata_o (dataWdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // both memories answer in the same cycle
    assign instr_i     = rom[instAddr_o[7:2]];
    assign dataRdata_i = ram[dataAddr_o[7:2]];

    assign storeFire  = dataEn_o && dataWe_o && !memStall_i;
    assign stallOn    = storeIdx >= PASS_STORES && storeIdx < STORES;
    assign expAddrNow = (storeIdx < STORES) ? expAddr[storeIdx] : 32'h0;
    assign expDataNow = (storeIdx < STORES) ? expData[storeIdx] : 32'h0;

    always @(posedge clk) begin
        if (storeFire) begin
            ram[dataAddr_o[7:2]] <= dataWdata_o;
        end
    end

    always @(posedge clk) begin
        if (rst_i) begin
            storeIdx <= 0;
        end else if (storeFire) begin
            storeIdx <= storeIdx + 1;
        end
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        memStall_i <= stallOn && !rst_i && rnd[0];
    end

    function automatic int storeTest(input int idx);
        if (idx >= PASS_STORES) begin
            return 4;
        end
        if (idx < 6) begin
            return 1;
        end
        return (idx == 6) ? 2 : 3;
    endfunction

    task automatic reportValue(input int test, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        fails[test]++;
        $display("[FAIL] %s %s expected %h actual %h", testNames[test], what, exp, act);
    endtask

    task automatic reportText(input int test, input string msg);
        fails[test]++;
        $display("error: %s", msg);
    endtask

    resetPc: assert property (@(posedge clk) $fell(rst_i) |-> instAddr_o == 32'h0 && instEn_o)
        else reportValue(0, "instAddr_o", 32'h0, $sampled(instAddr_o));

    noEarlyData: assert property (@(posedge clk) disable iff (rst_i)
        storeIdx == 0 && !storeFire |-> !dataEn_o && !dataWe_o)
        else reportText(0, "data port active before the first store");

    storeAddr: assert property (@(posedge clk) disable iff (rst_i)
        storeFire && storeIdx < STORES |-> dataAddr_o == expAddrNow)
        else reportValue(storeTest($sampled(storeIdx)), "dataAddr_o", $sampled(expAddrNow),
                         $sampled(dataAddr_o));

    storeData: assert property (@(posedge clk) disable iff (rst_i)
        storeFire && storeIdx < STORES |-> dataWdata_o == expDataNow)
        else reportValue(storeTest($sampled(storeIdx)), "dataWdata_o", $sampled(expDataNow),
                         $sampled(dataWdata_o));

    skippedStore: assert property (@(posedge clk) disable iff (rst_i)
        storeFire |-> dataAddr_o != 32'd56 && dataAddr_o != 32'd60)
        else reportText(storeTest($sampled(storeIdx)),
                        "a store that control flow should skip reached the data port");

    noExtraStore: assert property (@(posedge clk) disable iff (rst_i)
        storeFire |-> storeIdx < STORES)
        else reportText(5, "a store arrived beyond the expected table");

    portHeld: assert property (@(posedge clk) disable iff (rst_i)
        memStall_i |=> $stable(dataAddr_o) && $stable(dataWdata_o) && $stable(dataEn_o)
                       && $stable(dataWe_o))
        else reportText(4, "data port changed while memStall_i was high");

    task automatic waitStores(input int target);
        int cycles;
        cycles = 0;
        while (!timedOut && storeIdx < target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!timedOut && storeIdx < target) begin
            timedOut = 1'b1;
            $display("timeout: %0d of %0d stores arrived", storeIdx, target);
        end
    endtask

    task automatic summarizeTest(input int test);
        $display("%-12s %0d errors", testNames[test], fails[test]);
    endtask

    initial begin
        int total;
        int clean;
        rst_i        = 1'b1;
        memStall_i   = 1'b0;
        timedOut     = 1'b0;
        seed         = 32'he22d_bb51;
        total        = 0;
        clean        = 0;
        testNames[0] = "resetState";
        testNames[1] = "aluChain";
        testNames[2] = "loadUse";
        testNames[3] = "controlFlow";
        testNames[4] = "backPressure";
        testNames[5] = "completion";
        for (int i = 0; i < 6; i++) begin
            fails[i] = 0;
        end
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'hd000_0000 + i;
        end
        loadProgram();
        loadExpected();
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;

        waitStores(1);
        summarizeTest(0);
        waitStores(6);
        summarizeTest(1);
        waitStores(7);
        summarizeTest(2);
        waitStores(10);
        summarizeTest(3);
        waitStores(20);
        summarizeTest(4);
        for (int i = 0; i < 60; i++) begin
            @(negedge clk);  // watch for late extra stores
        end
        storeCount: assert (storeIdx == STORES)
            else reportValue(5, "store count", STORES, storeIdx);
        summarizeTest(5);

        for (int i = 0; i < 6; i++) begin
            total += fails[i];
            if (fails[i] == 0) begin
                clean++;
            end
        end
        $display("%0d of 6 tests clean, %0d errors, timeout %0d", clean, total, timedOut);
        if (timedOut || total > 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tb
common/mipsPkg.sv
fetch/fetchStage.sv
source/regFile.sv
source/decodeUnit.sv
source/hazardUnit.sv
execute/executeStage.sv
memwb/memStage.sv
source/mipsCore.sv
tb/tbMipsCore.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbMipsCore -f tb.f -Mdir obj_dir \
    && ./obj_dir/VtbMipsCore | tee /dev/stderr | grep -qx "Test passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
